/* list.f */
+incdir+tb
rtl/axis_fifo_pkg.sv
rtl/fifo_rst_sync.sv
rtl/gray_ptr_sync.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_rd_ctrl.sv
rtl/fifo_dp_ram.sv
rtl/axis_async_fifo.sv
tb/tb_axis_async_fifo.sv

/* tb/tb_fifo_checks.svh */
`ifndef TB_FIFO_CHECKS_SVH
`define TB_FIFO_CHECKS_SVH

// deterministic pseudo-random word for a stream index
// packed as last, user, keep, data from the top bit down
function automatic word_t gen_word(input int unsigned idx, input logic [63:0] salt);
    logic [63:0] x;
    logic [63:0] y;
    data_t       data;
    keep_t       keep;
    logic        last;
    logic        user;
    x = salt ^ (64'(idx) * 64'h9e37_79b9_7f4a_7c15);
    x = x ^ (x >> 30);
    x = x * 64'hbf58_476d_1ce4_e5b9;
    x = x ^ (x >> 27);
    y = x * 64'h94d0_49bb_1331_11eb;
    y = y ^ (y >> 31);
    data = x;
    keep = y[7:0];
    last = y[21];
    user = y[44];
    return {last, user, keep, data};
endfunction

task automatic check_data(input string what, input data_t exp, input data_t act);
    check_total++;
    if (act !== exp) begin
        error_total++;
        $display("FAIL [%s] %s: expected %h, actual %h", test_name, what, exp, act);
    end
endtask

task automatic check_keep(input string what, input keep_t exp, input keep_t act);
    check_total++;
    if (act !== exp) begin
        error_total++;
        $display("FAIL [%s] %s: expected %h, actual %h", test_name, what, exp, act);
    end
endtask

// single-bit results such as tlast, tuser, tvalid, tready
task automatic check_flag(input string what, input logic exp, input logic act);
    check_total++;
    if (act !== exp) begin
        error_total++;
        $display("FAIL [%s] %s: expected %b, actual %b", test_name, what, exp, act);
    end
endtask

task automatic check_count(input string what, input int exp, input int act);
    check_total++;
    if (act != exp) begin
        error_total++;
        $display("FAIL [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
endtask

`endif

/* tb/tb_axis_async_fifo.sv */
`timescale 1ns/1ps

module tb_axis_async_fifo import axis_fifo_pkg::*; ();

    localparam int ADDR_WIDTH  = 4;
    localparam int FIFO_DEPTH  = 1 << ADDR_WIDTH;
    localparam int OUT_PERIOD  = 20;
    localparam int IN_PERIOD   = 14;
    localparam int TOTAL_WORDS = 300 + 500 + 1 + FIFO_DEPTH + 10 + 40;
    localparam int WATCHDOG_NS = (TOTAL_WORDS * 200 + 1000) * OUT_PERIOD;

    logic  input_clk;
    logic  input_rst;
    data_t input_axis_tdata;
    keep_t input_axis_tkeep;
    logic  input_axis_tvalid;
    logic  input_axis_tready;
    logic  input_axis_tlast;
    logic  input_axis_tuser;

    logic  output_clk;
    logic  output_rst;
    data_t output_axis_tdata;
    keep_t output_axis_tkeep;
    logic  output_axis_tvalid;
    logic  output_axis_tready;
    logic  output_axis_tlast;
    logic  output_axis_tuser;

    word_t       exp_q[$];
    word_t       exp_word;
    int unsigned word_idx;
    logic [63:0] salt;
    string       test_name;
    int          error_total;
    int          check_total;
    int          sink_mode;
    logic        in_reset;

    // last stalled output, for the hold check
    logic  stalled;
    data_t held_data;
    keep_t held_keep;
    logic  held_last;
    logic  held_user;

    `include "tb_fifo_checks.svh"

    axis_async_fifo #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) uut (
        .input_clk          (input_clk),
        .input_rst          (input_rst),
        .input_axis_tdata   (input_axis_tdata),
        .input_axis_tkeep   (input_axis_tkeep),
        .input_axis_tvalid  (input_axis_tvalid),
        .input_axis_tready  (input_axis_tready),
        .input_axis_tlast   (input_axis_tlast),
        .input_axis_tuser   (input_axis_tuser),
        .output_clk         (output_clk),
        .output_rst         (output_rst),
        .output_axis_tdata  (output_axis_tdata),
        .output_axis_tkeep  (output_axis_tkeep),
        .output_axis_tvalid (output_axis_tvalid),
        .output_axis_tready (output_axis_tready),
        .output_axis_tlast  (output_axis_tlast),
        .output_axis_tuser  (output_axis_tuser)
    );

    initial begin
        output_clk = 1'b0;
        forever #(OUT_PERIOD / 2) output_clk = ~output_clk;
    end

    initial begin
        input_clk = 1'b0;
        forever #(IN_PERIOD / 2.0) input_clk = ~input_clk;
    end

    task automatic drive_word(input word_t w, input logic valid);
        {input_axis_tlast, input_axis_tuser, input_axis_tkeep, input_axis_tdata} = w;
        input_axis_tvalid = valid;
    endtask

    // source with valid_pct percent chance of offering a word each cycle
    task automatic send_words(input int count, input int valid_pct);
        int    sent;
        word_t w;
        sent = 0;
        @(posedge input_clk);
        #2;
        while (sent < count) begin
            if ($urandom_range(99) < valid_pct) begin
                w = gen_word(word_idx, salt);
                drive_word(w, 1'b1);
                @(posedge input_clk);
                while (!input_axis_tready) begin
                    @(posedge input_clk);
                end
                exp_q.push_back(w);
                word_idx++;
                sent++;
            end else begin
                input_axis_tvalid = 1'b0;
                @(posedge input_clk);
            end
            #2;
        end
        input_axis_tvalid = 1'b0;
    endtask

    task automatic sink_driver();
        forever begin
            @(posedge output_clk);
            #2;
            case (sink_mode)
                0:       output_axis_tready = 1'b1;
                1:       output_axis_tready = ($urandom_range(99) < 60);
                default: output_axis_tready = 1'b0;
            endcase
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge output_clk);
            check_flag("idle_tvalid", 1'b0, output_axis_tvalid);
            check_flag("idle_tready", 1'b1, input_axis_tready);
        end
    endtask

    // drained once output tvalid has stayed low for a while
    task automatic wait_drain();
        int idle;
        idle = 0;
        while (idle < 20) begin
            @(posedge output_clk);
            if (output_axis_tvalid) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
        check_count("queue_after_drain", 0, exp_q.size());
        repeat (20) begin
            @(posedge output_clk);
            check_flag("tvalid_after_drain", 1'b0, output_axis_tvalid);
        end
    endtask

    // offers words back to back until tready drops
    task automatic fill_until_full(output int accepted);
        accepted = 0;
        @(posedge input_clk);
        #2;
        drive_word(gen_word(word_idx, salt), 1'b1);
        while (accepted < 4 * FIFO_DEPTH) begin
            @(posedge input_clk);
            if (!input_axis_tready) begin
                break;
            end
            exp_q.push_back(gen_word(word_idx, salt));
            word_idx++;
            accepted++;
            #2;
            drive_word(gen_word(word_idx, salt), 1'b1);
        end
        #2;
        input_axis_tvalid = 1'b0;
    endtask

    task automatic run_fill();
        int accepted;
        send_words(1, 100);
        while (!output_axis_tvalid) begin
            @(posedge output_clk);
        end
        // read pointer has to reach the write side first
        repeat (8) @(posedge input_clk);
        fill_until_full(accepted);
        check_count("accepted_before_full", FIFO_DEPTH, accepted);
        repeat (20) begin
            @(posedge input_clk);
            check_flag("tready_while_full", 1'b0, input_axis_tready);
        end
    endtask

    task automatic apply_output_reset();
        @(posedge output_clk);
        #2;
        in_reset   = 1'b1;
        output_rst = 1'b1;
        exp_q.delete();
        repeat (3) @(posedge output_clk);
        #2;
        output_rst = 1'b0;
        repeat (6) @(posedge output_clk);
        #2;
        in_reset = 1'b0;
    endtask

    // scoreboard
    always @(posedge output_clk) begin
        if (in_reset) begin
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                check_flag("stall_tvalid", 1'b1, output_axis_tvalid);
                check_data("stall_tdata", held_data, output_axis_tdata);
                check_keep("stall_tkeep", held_keep, output_axis_tkeep);
                check_flag("stall_tlast", held_last, output_axis_tlast);
                check_flag("stall_tuser", held_user, output_axis_tuser);
            end
            if (output_axis_tvalid && output_axis_tready) begin
                if (exp_q.size() == 0) begin
                    error_total++;
                    $display("ERROR [%s] output handshake with no word expected", test_name);
                end else begin
                    exp_word = exp_q.pop_front();
                    check_data("tdata", exp_word[DATA_WIDTH-1:0], output_axis_tdata);
                    check_keep("tkeep", exp_word[DATA_WIDTH +: KEEP_WIDTH], output_axis_tkeep);
                    check_flag("tuser", exp_word[WORD_WIDTH-2], output_axis_tuser);
                    check_flag("tlast", exp_word[WORD_WIDTH-1], output_axis_tlast);
                end
            end
            stalled   = output_axis_tvalid && !output_axis_tready;
            held_data = output_axis_tdata;
            held_keep = output_axis_tkeep;
            held_last = output_axis_tlast;
            held_user = output_axis_tuser;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, %0d words still expected",
                 WATCHDOG_NS, exp_q.size());
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(22));
        salt = {$urandom, $urandom};
        word_idx    = 0;
        error_total = 0;
        check_total = 0;
        stalled     = 1'b0;
        in_reset    = 1'b1;
        sink_mode   = 2;
        test_name   = "reset";
        input_rst   = 1'b1;
        output_rst  = 1'b1;
        drive_word('0, 1'b0);
        output_axis_tready = 1'b0;
        fork
            sink_driver();
        join_none

        repeat (3) @(posedge output_clk);
        #2;
        input_rst  = 1'b0;
        output_rst = 1'b0;
        repeat (6) @(posedge output_clk);
        #2;
        in_reset = 1'b0;

        test_name = "after_reset";
        check_idle(20);

        test_name = "stream";
        sink_mode = 0;
        send_words(300, 100);
        wait_drain();

        test_name = "random";
        sink_mode = 1;
        send_words(500, 70);
        wait_drain();

        test_name = "fill";
        sink_mode = 2;
        run_fill();
        sink_mode = 0;
        wait_drain();

        // stalled words get thrown away by the reset
        test_name = "output_reset";
        sink_mode = 2;
        send_words(10, 100);
        repeat (10) @(posedge output_clk);
        apply_output_reset();
        sink_mode = 0;
        check_idle(20);
        test_name = "after_output_reset";
        send_words(40, 100);
        wait_drain();

        $display("checks: %0d, errors: %0d", check_total, error_total);
        if (error_total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* rtl/axis_async_fifo.sv */
`timescale 1ns/1ps

module axis_async_fifo import axis_fifo_pkg::*; #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic  input_clk,
    input  logic  input_rst,
    input  data_t input_axis_tdata,
    input  keep_t input_axis_tkeep,
    input  logic  input_axis_tvalid,
    output logic  input_axis_tready,
    input  logic  input_axis_tlast,
    input  logic  input_axis_tuser,

    input  logic  output_clk,
    input  logic  output_rst,
    output data_t output_axis_tdata,
    output keep_t output_axis_tkeep,
    output logic  output_axis_tvalid,
    input  logic  output_axis_tready,
    output logic  output_axis_tlast,
    output logic  output_axis_tuser
);

    logic input_rst_sync2;
    logic output_rst_sync2;

    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [ADDR_WIDTH:0]   wr_ptr_gray;
    logic [ADDR_WIDTH:0]   wr_ptr_gray_sync;

    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [ADDR_WIDTH:0]   rd_ptr_gray;
    logic [ADDR_WIDTH:0]   rd_ptr_gray_sync;

    word_t wr_data;
    word_t rd_data;

    // last, user, keep, data from the top down
    assign wr_data = {input_axis_tlast, input_axis_tuser, input_axis_tkeep, input_axis_tdata};
    assign {output_axis_tlast, output_axis_tuser, output_axis_tkeep, output_axis_tdata} = rd_data;

    fifo_rst_sync rst_sync (
        .input_clk        (input_clk),
        .output_clk       (output_clk),
        .input_rst        (input_rst),
        .output_rst       (output_rst),
        .input_rst_sync2  (input_rst_sync2),
        .output_rst_sync2 (output_rst_sync2)
    );

    fifo_wr_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) wr_ctrl (
        .input_clk        (input_clk),
        .input_rst_sync2  (input_rst_sync2),
        .tvalid           (input_axis_tvalid),
        .tready           (input_axis_tready),
        .rd_ptr_gray_sync (rd_ptr_gray_sync),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_ptr_gray      (wr_ptr_gray)
    );

    // write pointer into the read domain
    gray_ptr_sync #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) wr_ptr_sync (
        .clk      (output_clk),
        .rst      (output_rst_sync2),
        .gray_in  (wr_ptr_gray),
        .gray_out (wr_ptr_gray_sync)
    );

    // read pointer into the write domain
    gray_ptr_sync #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) rd_ptr_sync (
        .clk      (input_clk),
        .rst      (input_rst_sync2),
        .gray_in  (rd_ptr_gray),
        .gray_out (rd_ptr_gray_sync)
    );

    fifo_rd_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) rd_ctrl (
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .tready           (output_axis_tready),
        .tvalid           (output_axis_tvalid),
        .wr_ptr_gray_sync (wr_ptr_gray_sync),
        .rd_en            (rd_en),
        .rd_addr          (rd_addr),
        .rd_ptr_gray      (rd_ptr_gray)
    );

    fifo_dp_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) dp_ram (
        .input_clk        (input_clk),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .rd_en            (rd_en),
        .rd_addr          (rd_addr),
        .rd_data          (rd_data)
    );

endmodule

/* rtl/fifo_dp_ram.sv */
`timescale 1ns/1ps

module fifo_dp_ram import axis_fifo_pkg::*; #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  input_clk,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  word_t                 wr_data,
    input  logic                  output_clk,
    input  logic                  output_rst_sync2,
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output word_t                 rd_data
);

    word_t mem [0:(2**ADDR_WIDTH)-1];

    always_ff @(posedge input_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read register is also the stream output register
    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* rtl/fifo_rd_ctrl.sv */
`timescale 1ns/1ps

module fifo_rd_ctrl import axis_fifo_pkg::*; #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  output_clk,
    input  logic                  output_rst_sync2,
    input  logic                  tready,
    output logic                  tvalid,
    input  logic [ADDR_WIDTH:0]   wr_ptr_gray_sync,
    output logic                  rd_en,
    output logic [ADDR_WIDTH-1:0] rd_addr,
    output logic [ADDR_WIDTH:0]   rd_ptr_gray
);

    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

    logic [ADDR_WIDTH:0] rd_ptr;
    logic [ADDR_WIDTH:0] rd_ptr_next;
    logic                empty;
    logic                out_free;
    logic [ADDR_WIDTH:0] wr_ptr_bin_sync;

    // exact match means nothing left to read
    assign empty = (rd_ptr_gray == wr_ptr_gray_sync);

    // output register free or being consumed this cycle
    assign out_free = tready || !tvalid;

    assign rd_en       = !empty && out_free;
    assign rd_addr     = rd_ptr[ADDR_WIDTH-1:0];
    assign rd_ptr_next = rd_ptr + 1'b1;

    // binary copy of the synchronized write pointer
    always_comb begin
        for (int i = 0; i <= ADDR_WIDTH; i++) begin
            wr_ptr_bin_sync[i] = ^(wr_ptr_gray_sync >> i);
        end
    end

    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
        end else if (rd_en) begin
            rd_ptr      <= rd_ptr_next;
            rd_ptr_gray <= PTR_WIDTH'(bin_to_gray(PTR_MAX_WIDTH'(rd_ptr_next)));
        end
    end

    // valid follows the memory read port
    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            tvalid <= 1'b0;
        end else if (out_free) begin
            tvalid <= !empty;
        end
    end

    // reader stays behind the writer, and at most one memory depth behind
    a_ptr_distance: assert property (
        @(posedge output_clk) disable iff (output_rst_sync2)
        PTR_WIDTH'(wr_ptr_bin_sync - rd_ptr) <= PTR_WIDTH'(2**ADDR_WIDTH)
    );

    a_rd_gray_one_bit: assert property (
        @(posedge output_clk) disable iff (output_rst_sync2)
        $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1
    );

endmodule

/* rtl/fifo_wr_ctrl.sv */
`timescale 1ns/1ps

module fifo_wr_ctrl import axis_fifo_pkg::*; #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  input_clk,
    input  logic                  input_rst_sync2,
    input  logic                  tvalid,
    output logic                  tready,
    input  logic [ADDR_WIDTH:0]   rd_ptr_gray_sync,
    output logic                  wr_en,
    output logic [ADDR_WIDTH-1:0] wr_addr,
    output logic [ADDR_WIDTH:0]   wr_ptr_gray
);

    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] wr_ptr_next;
    logic                full;
    logic [ADDR_WIDTH:0] rd_ptr_bin_sync;

    // top two gray bits differ, rest equal
    assign full = (wr_ptr_gray[ADDR_WIDTH] != rd_ptr_gray_sync[ADDR_WIDTH]) &&
                  (wr_ptr_gray[ADDR_WIDTH-1] != rd_ptr_gray_sync[ADDR_WIDTH-1]) &&
                  (wr_ptr_gray[ADDR_WIDTH-2:0] == rd_ptr_gray_sync[ADDR_WIDTH-2:0]);

    assign tready      = !full && !input_rst_sync2;
    assign wr_en       = tvalid && tready;
    assign wr_addr     = wr_ptr[ADDR_WIDTH-1:0];
    assign wr_ptr_next = wr_ptr + 1'b1;

    // binary copy of the synchronized read pointer
    always_comb begin
        for (int i = 0; i <= ADDR_WIDTH; i++) begin
            rd_ptr_bin_sync[i] = ^(rd_ptr_gray_sync >> i);
        end
    end

    always_ff @(posedge input_clk or posedge input_rst_sync2) begin
        if (input_rst_sync2) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
        end else if (wr_en) begin
            wr_ptr      <= wr_ptr_next;
            wr_ptr_gray <= PTR_WIDTH'(bin_to_gray(PTR_MAX_WIDTH'(wr_ptr_next)));
        end
    end

    // writer never runs more than the memory depth ahead of the reader
    a_no_overflow: assert property (
        @(posedge input_clk) disable iff (input_rst_sync2)
        PTR_WIDTH'(wr_ptr - rd_ptr_bin_sync) <= PTR_WIDTH'(2**ADDR_WIDTH)
    );

    // the read domain samples this pointer asynchronously
    a_wr_gray_one_bit: assert property (
        @(posedge input_clk) disable iff (input_rst_sync2)
        $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1
    );

endmodule

/* rtl/gray_ptr_sync.sv */
`timescale 1ns/1ps

module gray_ptr_sync #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [ADDR_WIDTH:0] gray_in,
    output logic [ADDR_WIDTH:0] gray_out
);

    // first stage may go metastable
    logic [ADDR_WIDTH:0] gray_sync1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gray_sync1 <= '0;
            gray_out   <= '0;
        end else begin
            gray_sync1 <= gray_in;
            gray_out   <= gray_sync1;
        end
    end

endmodule

/* rtl/fifo_rst_sync.sv */
`timescale 1ns/1ps

module fifo_rst_sync (
    input  logic input_clk,
    input  logic output_clk,
    input  logic input_rst,
    input  logic output_rst,
    output logic input_rst_sync2,
    output logic output_rst_sync2
);

    logic input_rst_sync1;
    logic output_rst_sync1;

    // either raw reset clears the write side
    always_ff @(posedge input_clk or posedge input_rst or posedge output_rst) begin
        if (input_rst || output_rst) begin
            input_rst_sync1 <= 1'b1;
            input_rst_sync2 <= 1'b1;
        end else begin
            input_rst_sync1 <= 1'b0;
            input_rst_sync2 <= input_rst_sync1;
        end
    end

    // and the read side as well
    always_ff @(posedge output_clk or posedge input_rst or posedge output_rst) begin
        if (input_rst || output_rst) begin
            output_rst_sync1 <= 1'b1;
            output_rst_sync2 <= 1'b1;
        end else begin
            output_rst_sync1 <= 1'b0;
            output_rst_sync2 <= output_rst_sync1;
        end
    end

endmodule

/* rtl/axis_fifo_pkg.sv */
package axis_fifo_pkg;

    // payload widths for the 64-bit variant
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    // last, user, keep, data from the top bit down
    localparam int WORD_WIDTH = DATA_WIDTH + KEEP_WIDTH + 2;

    // widest pointer the gray helper accepts
    localparam int PTR_MAX_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [KEEP_WIDTH-1:0] keep_t;
    typedef logic [WORD_WIDTH-1:0] word_t;

    // binary-reflected gray code
    // callers zero-extend into the wide argument and truncate the result,
    // which leaves the low bits unchanged
    function automatic logic [PTR_MAX_WIDTH-1:0] bin_to_gray(
        input logic [PTR_MAX_WIDTH-1:0] bin
    );
        return bin ^ (bin >> 1);
    endfunction

endpackage
